//--- hw/aluUnit.sv
module aluUnit (
    input  cpuPkg::aluOpT                 aluOp,
    input  logic [cpuPkg::dataWidth-1:0]  a,
    input  logic [cpuPkg::dataWidth-1:0]  b,
    output logic [cpuPkg::dataWidth-1:0]  result,
    output logic                          neg,
    output logic                          zero
);

    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd: begin
                result = a + b;
            end
            cpuPkg::aluSub: begin
                result = a - b;
            end
            cpuPkg::aluOr: begin
                result = a | b;
            end
            cpuPkg::aluNand: begin
                result = ~(a & b);
            end
            cpuPkg::aluShl: begin
                result = a << b;   // Logical, zero fill
            end
            cpuPkg::aluShr: begin
                result = a >> b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Flags come straight off the result
    assign neg = result[cpuPkg::dataWidth-1];
    assign zero = (result == '0);

endmodule

//--- hw/controlFsm.sv
module controlFsm (
    input  logic                          CLOCK_50,
    input  logic                          rstN,
    input  logic                          run,
    input  logic [cpuPkg::dataWidth-1:0]  opcode,
    input  logic                          flagN,
    input  logic                          flagZ,
    output logic                          pcWrite,
    output logic                          addrSel,
    output logic                          irLoad,
    output logic                          mdrLoad,
    output logic                          raSel,
    output logic                          rfWrite,
    output logic                          regIn,
    output logic                          abLoad,
    output logic                          aluASel,
    output logic                          flagWrite,
    output logic                          aluOutLoad,
    output logic                          memWrite,
    output cpuPkg::bSelT                  aluBSel,
    output cpuPkg::aluOpT                 aluOp
);

    cpuPkg::stateT state;
    cpuPkg::stateT nextState;
    cpuPkg::stateT endState;
    cpuPkg::opcodeT op;
    logic isArith;
    logic isShift;
    logic isOri;
    logic isBranch;
    logic branchTaken;

    assign op = cpuPkg::opcodeT'(opcode[3:0]);
    assign isArith = (op == cpuPkg::opAdd) || (op == cpuPkg::opSub) || (op == cpuPkg::opNand);
    assign isShift = (opcode[2:0] == cpuPkg::shiftCode);
    assign isOri = (opcode[2:0] == cpuPkg::oriCode);
    assign isBranch = (op == cpuPkg::opBz) || (op == cpuPkg::opBnz) ||
                      (op == cpuPkg::opBpz) || (op == cpuPkg::opJ);

    // Branch conditions on the stored flags
    always_comb begin
        case (op)
            cpuPkg::opBz:  branchTaken = flagZ;
            cpuPkg::opBnz: branchTaken = !flagZ;
            cpuPkg::opBpz: branchTaken = !flagN;
            default:       branchTaken = 1'b1;   // J
        endcase
    end

    // Drop back to IDLE after an instruction if run went away
    assign endState = run ? cpuPkg::sFetch : cpuPkg::sIdle;

    always_comb begin
        case (state)
            cpuPkg::sIdle:   nextState = run ? cpuPkg::sFetch : cpuPkg::sIdle;
            cpuPkg::sFetch:  nextState = cpuPkg::sDecode;
            cpuPkg::sDecode: nextState = cpuPkg::sExec;
            cpuPkg::sExec: begin
                if (isArith || isShift || isOri || op == cpuPkg::opLoad) begin
                    nextState = cpuPkg::sWrite;
                end else begin
                    nextState = endState;   // STORE, branches, no-ops
                end
            end
            cpuPkg::sWrite:  nextState = isOri ? cpuPkg::sOriWb : endState;
            default:         nextState = endState;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge rstN) begin
        if (!rstN) begin
            state <= cpuPkg::sIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        pcWrite = 1'b0;
        addrSel = 1'b0;
        irLoad = 1'b0;
        mdrLoad = 1'b0;
        raSel = 1'b0;
        rfWrite = 1'b0;
        regIn = 1'b0;
        abLoad = 1'b0;
        aluASel = 1'b0;
        flagWrite = 1'b0;
        aluOutLoad = 1'b0;
        memWrite = 1'b0;
        aluBSel = cpuPkg::bRegB;
        aluOp = cpuPkg::aluAdd;
        case (state)
            cpuPkg::sFetch: begin
                addrSel = 1'b1;   // IR <- mem[PC]
                irLoad = 1'b1;
                aluBSel = cpuPkg::bOne;   // PC <- PC + 1
                pcWrite = 1'b1;
            end
            cpuPkg::sDecode: begin
                abLoad = 1'b1;
            end
            cpuPkg::sExec: begin
                if (isArith) begin
                    aluASel = 1'b1;
                    aluOutLoad = 1'b1;
                    flagWrite = 1'b1;
                    if (op == cpuPkg::opSub) begin
                        aluOp = cpuPkg::aluSub;
                    end else if (op == cpuPkg::opNand) begin
                        aluOp = cpuPkg::aluNand;
                    end
                end else if (isShift) begin
                    aluASel = 1'b1;
                    aluBSel = cpuPkg::bShAmt;
                    aluOp = opcode[5] ? cpuPkg::aluShl : cpuPkg::aluShr;
                    aluOutLoad = 1'b1;
                    flagWrite = 1'b1;
                end else if (isOri) begin
                    // Reload A with r1
                    raSel = 1'b1;
                    abLoad = 1'b1;
                end else if (op == cpuPkg::opLoad) begin
                    mdrLoad = 1'b1;   // Address comes from B
                end else if (op == cpuPkg::opStore) begin
                    memWrite = 1'b1;
                end else if (isBranch) begin
                    aluBSel = cpuPkg::bOffset;
                    pcWrite = branchTaken;
                end
            end
            cpuPkg::sWrite: begin
                if (isOri) begin
                    aluASel = 1'b1;
                    aluBSel = cpuPkg::bOriImm;
                    aluOp = cpuPkg::aluOr;
                    aluOutLoad = 1'b1;
                    flagWrite = 1'b1;
                end else begin
                    regIn = (op == cpuPkg::opLoad);   // MDR for LOAD, else result
                    rfWrite = 1'b1;
                end
            end
            cpuPkg::sOriWb: begin
                raSel = 1'b1;
                rfWrite = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Fetch reads memory in the cycle it would otherwise be written
    fetchNoStore: assert property (@(posedge CLOCK_50) disable iff (!rstN)
        !(irLoad && memWrite))
        else $error("instruction fetch overlapped a store");

    idleHold: assert property (@(posedge CLOCK_50) disable iff (!rstN)
        (state == cpuPkg::sIdle && !run) |=> (state == cpuPkg::sIdle))
        else $error("controller left IDLE without run");

endmodule

//--- hw/cpuPkg.sv
package cpuPkg;

    localparam int dataWidth = 8;    // Data and address width
    localparam int memDepth = 256;   // Words in the unified memory
    localparam int regCount = 4;     // General registers r0..r3

    // Low nibble of IR for the full 4-bit opcodes
    typedef enum logic [3:0] {
        opLoad  = 4'b0000,
        opJ     = 4'b0001,
        opStore = 4'b0010,
        opAdd   = 4'b0100,
        opBnz   = 4'b0101,
        opSub   = 4'b0110,
        opNand  = 4'b1000,
        opBpz   = 4'b1001,
        opBz    = 4'b1010
    } opcodeT;

    // These two only decode IR[2:0]
    localparam logic [2:0] oriCode = 3'b111;
    localparam logic [2:0] shiftCode = 3'b011;

    typedef enum logic [2:0] {
        sIdle   = 3'd0,
        sFetch  = 3'd1,
        sDecode = 3'd2,
        sExec   = 3'd3,
        sWrite  = 3'd4,
        sOriWb  = 3'd5
    } stateT;

    typedef enum logic [2:0] {
        aluAdd  = 3'd0,
        aluSub  = 3'd1,
        aluOr   = 3'd2,
        aluNand = 3'd3,
        aluShl  = 3'd4,
        aluShr  = 3'd5
    } aluOpT;

    // Second ALU operand source
    typedef enum logic [2:0] {
        bRegB   = 3'd0,   // B operand register
        bOne    = 3'd1,   // PC increment
        bOffset = 3'd2,   // Sign-extended IR[7:4]
        bOriImm = 3'd3,   // Zero-extended IR[7:3]
        bShAmt  = 3'd4    // Zero-extended IR[4:3]
    } bSelT;

    // Clock cycles per instruction class including FETCH
    localparam int cycleAlu = 4;
    localparam int cycleLoad = 4;
    localparam int cycleStore = 3;
    localparam int cycleBranch = 3;
    localparam int cycleNop = 3;
    localparam int cycleOri = 5;

endpackage

//--- hw/cpuTop.sv
module cpuTop (
    input  logic                          CLOCK_50,
    input  logic                          rstN,
    input  logic                          run,
    input  logic                          loadEn,
    input  logic [cpuPkg::dataWidth-1:0]  loadAddr,
    input  logic [cpuPkg::dataWidth-1:0]  loadData,
    output logic                          storeStrobe,
    output logic [cpuPkg::dataWidth-1:0]  storeAddr,
    output logic [cpuPkg::dataWidth-1:0]  storeData,
    output logic [cpuPkg::dataWidth-1:0]  pc
);

    logic pcWrite;
    logic addrSel;
    logic irLoad;
    logic mdrLoad;
    logic raSel;
    logic rfWrite;
    logic regIn;
    logic abLoad;
    logic aluASel;
    logic flagWrite;
    logic aluOutLoad;
    logic memWrite;
    logic flagN;
    logic flagZ;
    cpuPkg::bSelT aluBSel;
    cpuPkg::aluOpT aluOp;
    logic [cpuPkg::dataWidth-1:0] opcode;
    logic [cpuPkg::dataWidth-1:0] memAddr;
    logic [cpuPkg::dataWidth-1:0] memWdata;
    logic [cpuPkg::dataWidth-1:0] rdData;

    controlFsm ctrl0 (
        .CLOCK_50   (CLOCK_50),
        .rstN       (rstN),
        .run        (run),
        .opcode     (opcode),
        .flagN      (flagN),
        .flagZ      (flagZ),
        .pcWrite    (pcWrite),
        .addrSel    (addrSel),
        .irLoad     (irLoad),
        .mdrLoad    (mdrLoad),
        .raSel      (raSel),
        .rfWrite    (rfWrite),
        .regIn      (regIn),
        .abLoad     (abLoad),
        .aluASel    (aluASel),
        .flagWrite  (flagWrite),
        .aluOutLoad (aluOutLoad),
        .memWrite   (memWrite),
        .aluBSel    (aluBSel),
        .aluOp      (aluOp)
    );

    dataPath path0 (
        .CLOCK_50   (CLOCK_50),
        .rstN       (rstN),
        .pcWrite    (pcWrite),
        .addrSel    (addrSel),
        .irLoad     (irLoad),
        .mdrLoad    (mdrLoad),
        .raSel      (raSel),
        .rfWrite    (rfWrite),
        .regIn      (regIn),
        .abLoad     (abLoad),
        .aluASel    (aluASel),
        .flagWrite  (flagWrite),
        .aluOutLoad (aluOutLoad),
        .aluBSel    (aluBSel),
        .aluOp      (aluOp),
        .rdData     (rdData),
        .memAddr    (memAddr),
        .memWdata   (memWdata),
        .opcode     (opcode),
        .pc         (pc),
        .flagN      (flagN),
        .flagZ      (flagZ)
    );

    mainMemory mem0 (
        .CLOCK_50 (CLOCK_50),
        .rstN     (rstN),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .rdData   (rdData)
    );

    // Store observation is the memory write port itself
    assign storeStrobe = memWrite;
    assign storeAddr = memAddr;
    assign storeData = memWdata;

endmodule

//--- hw/dataPath.sv
module dataPath (
    input  logic                          CLOCK_50,
    input  logic                          rstN,
    input  logic                          pcWrite,
    input  logic                          addrSel,
    input  logic                          irLoad,
    input  logic                          mdrLoad,
    input  logic                          raSel,
    input  logic                          rfWrite,
    input  logic                          regIn,
    input  logic                          abLoad,
    input  logic                          aluASel,
    input  logic                          flagWrite,
    input  logic                          aluOutLoad,
    input  cpuPkg::bSelT                  aluBSel,
    input  cpuPkg::aluOpT                 aluOp,
    input  logic [cpuPkg::dataWidth-1:0]  rdData,
    output logic [cpuPkg::dataWidth-1:0]  memAddr,
    output logic [cpuPkg::dataWidth-1:0]  memWdata,
    output logic [cpuPkg::dataWidth-1:0]  opcode,
    output logic [cpuPkg::dataWidth-1:0]  pc,
    output logic                          flagN,
    output logic                          flagZ
);

    logic [cpuPkg::dataWidth-1:0] ir;
    logic [cpuPkg::dataWidth-1:0] mdr;
    logic [cpuPkg::dataWidth-1:0] aReg;
    logic [cpuPkg::dataWidth-1:0] bReg;
    logic [cpuPkg::dataWidth-1:0] aluOut;
    logic [cpuPkg::dataWidth-1:0] rfDataA;
    logic [cpuPkg::dataWidth-1:0] rfDataB;
    logic [cpuPkg::dataWidth-1:0] dataW;
    logic [cpuPkg::dataWidth-1:0] aluA;
    logic [cpuPkg::dataWidth-1:0] aluB;
    logic [cpuPkg::dataWidth-1:0] aluResult;
    logic [1:0] rfIndex;
    logic aluNeg;
    logic aluZero;

    assign memAddr = addrSel ? pc : bReg;
    assign memWdata = aReg;   // STORE data is rA
    assign opcode = ir;

    // ORi always works on r1
    assign rfIndex = raSel ? 2'b01 : ir[7:6];
    assign dataW = regIn ? mdr : aluOut;

    regFile regs0 (
        .CLOCK_50 (CLOCK_50),
        .rstN     (rstN),
        .rfWrite  (rfWrite),
        .regA     (rfIndex),
        .regB     (ir[5:4]),
        .regW     (rfIndex),
        .dataW    (dataW),
        .dataA    (rfDataA),
        .dataB    (rfDataB)
    );

    assign aluA = aluASel ? aReg : pc;

    always_comb begin
        case (aluBSel)
            cpuPkg::bOne:    aluB = 8'd1;
            cpuPkg::bOffset: aluB = {{4{ir[7]}}, ir[7:4]};
            cpuPkg::bOriImm: aluB = {3'b000, ir[7:3]};
            cpuPkg::bShAmt:  aluB = {6'b000000, ir[4:3]};
            default:         aluB = bReg;
        endcase
    end

    aluUnit alu0 (
        .aluOp  (aluOp),
        .a      (aluA),
        .b      (aluB),
        .result (aluResult),
        .neg    (aluNeg),
        .zero   (aluZero)
    );

    always_ff @(posedge CLOCK_50 or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            ir <= '0;
            mdr <= '0;
            aReg <= '0;
            bReg <= '0;
            aluOut <= '0;
            flagN <= 1'b0;
            flagZ <= 1'b0;
        end else begin
            if (pcWrite) pc <= aluResult;   // Increment or branch target
            if (irLoad) ir <= rdData;
            if (mdrLoad) mdr <= rdData;
            if (abLoad) begin
                aReg <= rfDataA;
                bReg <= rfDataB;
            end
            if (aluOutLoad) aluOut <= aluResult;
            if (flagWrite) begin
                flagN <= aluNeg;
                flagZ <= aluZero;
            end
        end
    end

    // PC and register file are never written in one cycle
    pcVsRf: assert property (@(posedge CLOCK_50) disable iff (!rstN)
        !(pcWrite && rfWrite))
        else $error("PC and register file written together");

endmodule

//--- hw/mainMemory.sv
module mainMemory (
    input  logic                          CLOCK_50,
    input  logic                          rstN,
    input  logic                          memWrite,
    input  logic [cpuPkg::dataWidth-1:0]  memAddr,
    input  logic [cpuPkg::dataWidth-1:0]  memWdata,
    input  logic                          loadEn,
    input  logic [cpuPkg::dataWidth-1:0]  loadAddr,
    input  logic [cpuPkg::dataWidth-1:0]  loadData,
    output logic [cpuPkg::dataWidth-1:0]  rdData
);

    logic [cpuPkg::dataWidth-1:0] mem [cpuPkg::memDepth];

    // Program loader wins over a core store
    always_ff @(posedge CLOCK_50) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end else if (memWrite) begin
            mem[memAddr] <= memWdata;
        end
    end

    // Asynchronous read so IR and MDR latch in the read cycle
    assign rdData = mem[memAddr];

    // Image loading only happens while the core sits idle
    loadVsStore: assert property (@(posedge CLOCK_50) disable iff (!rstN)
        !(loadEn && memWrite))
        else $error("memory load collided with a core store");

endmodule

//--- hw/regFile.sv
module regFile (
    input  logic                          CLOCK_50,
    input  logic                          rstN,
    input  logic                          rfWrite,
    input  logic [1:0]                    regA,
    input  logic [1:0]                    regB,
    input  logic [1:0]                    regW,
    input  logic [cpuPkg::dataWidth-1:0]  dataW,
    output logic [cpuPkg::dataWidth-1:0]  dataA,
    output logic [cpuPkg::dataWidth-1:0]  dataB
);

    logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];

    // Single write port
    always_ff @(posedge CLOCK_50 or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < cpuPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (rfWrite) begin
            regs[regW] <= dataW;
        end
    end

    // Both reads are combinational
    assign dataA = regs[regA];
    assign dataB = regs[regB];

endmodule

//--- include/tbPrograms.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// One row per program with the image bytes from address 0, the expected stores in order,
// the cycle of the first store after run rises and a cycle budget for the run

localparam int numPrograms = 4;
localparam int imageLen = 24;
localparam int maxStores = 6;

// Random operands live just past the images
localparam logic [7:0] xAddr = 8'h1E;
localparam logic [7:0] yAddr = 8'h1F;

// How the expected store data is formed
localparam int kindLit = 0;    // Literal from the table
localparam int kindSum = 1;    // x + y
localparam int kindDiff = 2;   // x - y
localparam int kindNand = 3;   // ~(x & y)
localparam int kindX = 4;      // x unchanged

localparam logic [7:0] progImage [numPrograms][imageLen] = '{
    // LOAD x and y, then NAND, ADD and SUB results stored to 1F
    '{8'hF7, 8'h90, 8'h0F, 8'hD0, 8'h24, 8'h38, 8'h12, 8'h06,
      8'h24, 8'h34, 8'h12, 8'hB6, 8'h92, 8'hF1, 8'h00, 8'h00,
      8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
    // ORi builds 17, then shifts left 3, right 2, left 0, right 1, ORi 1F
    '{8'hC7, 8'hD4, 8'h56, 8'h2F, 8'h97, 8'h72, 8'h7B, 8'h72,
      8'h53, 8'h72, 8'h63, 8'h72, 8'h4B, 8'h72, 8'hFF, 8'h72,
      8'hF1, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
    // Each branch hops over one STORE of 18 when taken
    '{8'hC7, 8'hD4, 8'h56, 8'h1A, 8'hF2, 8'h72, 8'h15, 8'hF2,
      8'h76, 8'h1A, 8'hF2, 8'h19, 8'h72, 8'h15, 8'hF2, 8'h74,
      8'h19, 8'hF2, 8'h11, 8'hF2, 8'h72, 8'hF1, 8'h00, 8'h00},
    // x stored to 18, read back into r0 and stored to 1C
    '{8'hF7, 8'h90, 8'h56, 8'hC7, 8'hD4, 8'hB2, 8'h27, 8'h30,
      8'h12, 8'hF1, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
      8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00}
};

localparam int storeCount [numPrograms] = '{3, 6, 5, 2};

localparam logic [7:0] storeAddrTab [numPrograms][maxStores] = '{
    '{8'h1F, 8'h1F, 8'h1F, 8'h00, 8'h00, 8'h00},
    '{8'h18, 8'h18, 8'h18, 8'h18, 8'h18, 8'h18},
    '{8'h18, 8'h18, 8'h18, 8'h18, 8'h18, 8'h00},
    '{8'h18, 8'h1C, 8'h00, 8'h00, 8'h00, 8'h00}
};

localparam int storeKind [numPrograms][maxStores] = '{
    '{kindNand, kindSum, kindDiff, kindLit, kindLit, kindLit},
    '{kindLit, kindLit, kindLit, kindLit, kindLit, kindLit},
    '{kindLit, kindLit, kindLit, kindLit, kindLit, kindLit},
    '{kindX, kindX, kindLit, kindLit, kindLit, kindLit}
};

localparam logic [7:0] storeLit [numPrograms][maxStores] = '{
    '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
    '{8'h17, 8'hB8, 8'h2E, 8'h2E, 8'h17, 8'h1F},
    '{8'h00, 8'h18, 8'h18, 8'hE8, 8'h00, 8'h00},
    '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00}
};

// Instructions up to and including the first STORE
localparam int firstStoreCycle [numPrograms] = '{
    2 * cpuPkg::cycleOri + 2 * cpuPkg::cycleLoad + 2 * cpuPkg::cycleAlu + cpuPkg::cycleStore,
    3 * cpuPkg::cycleOri + 2 * cpuPkg::cycleAlu + cpuPkg::cycleStore,
    cpuPkg::cycleOri + 2 * cpuPkg::cycleAlu + cpuPkg::cycleBranch + cpuPkg::cycleStore,
    2 * cpuPkg::cycleOri + cpuPkg::cycleLoad + 2 * cpuPkg::cycleAlu + cpuPkg::cycleStore
};

localparam int cycleBudget [numPrograms] = '{80, 90, 90, 60};

`endif

//--- test/cpuTb.sv
module cpuTb;

    timeunit 1ns;
    timeprecision 1ps;

    `include "tbPrograms.svh"

    localparam int clkPeriod = 40;

    logic CLOCK_50;
    logic rstN;
    logic run;
    logic loadEn;
    logic [7:0] loadAddr;
    logic [7:0] loadData;
    logic storeStrobe;
    logic [7:0] storeAddr;
    logic [7:0] storeData;
    logic [7:0] pc;

    int testsRun;
    int testsFailed;
    int errorCount;

    cpuTop dut0 (
        .CLOCK_50    (CLOCK_50),
        .rstN        (rstN),
        .run         (run),
        .loadEn      (loadEn),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .storeStrobe (storeStrobe),
        .storeAddr   (storeAddr),
        .storeData   (storeData),
        .pc          (pc)
    );

    always #(clkPeriod / 2) CLOCK_50 = ~CLOCK_50;

    // 8-bit wrap arithmetic as the ISA defines it
    function automatic logic [7:0] expectedData(int kind, logic [7:0] lit,
                                                logic [7:0] x, logic [7:0] y);
        case (kind)
            kindSum:  return x + y;
            kindDiff: return x - y;
            kindNand: return ~(x & y);
            kindX:    return x;
            default:  return lit;
        endcase
    endfunction

    function automatic string progLabel(int p);
        case (p)
            0:       return "arithmetic";
            1:       return "ori and shifts";
            2:       return "branches";
            default: return "memory";
        endcase
    endfunction

    task automatic finishTest(string name, int bad);
        testsRun++;
        if (bad != 0) testsFailed++;
        errorCount += bad;
        $display("%-16s %0d errors", name, bad);
    endtask

    task automatic resetCore();
        @(negedge CLOCK_50);
        rstN = 1'b0;
        run = 1'b0;
        loadEn = 1'b0;
        repeat (4) @(negedge CLOCK_50);
        rstN = 1'b1;
    endtask

    task automatic loadImage(int p, logic [7:0] x, logic [7:0] y);
        for (int i = 0; i < imageLen; i++) begin
            @(negedge CLOCK_50);
            loadEn = 1'b1;
            loadAddr = 8'(i);
            loadData = progImage[p][i];
        end
        @(negedge CLOCK_50);
        loadAddr = xAddr;
        loadData = x;
        @(negedge CLOCK_50);
        loadAddr = yAddr;
        loadData = y;
        @(negedge CLOCK_50);
        loadEn = 1'b0;
    endtask

    task automatic checkReset();
        int bad;
        bad = 0;
        resetCore();
        repeat (10) begin
            @(negedge CLOCK_50);
            if (pc !== 8'h00) begin
                $display("error at %0t: pc is %h while idle, expected 00", $time, pc);
                bad++;
            end
            if (storeStrobe !== 1'b0) begin
                $display("error at %0t: store strobe high while idle", $time);
                bad++;
            end
        end
        finishTest("reset", bad);
    endtask

    task automatic runProgram(int p);
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] want;
        int seen;
        int cycle;
        int bad;
        x = 8'($urandom());
        y = 8'($urandom());
        seen = 0;
        cycle = 0;
        bad = 0;
        resetCore();
        loadImage(p, x, y);
        run = 1'b1;   // FETCH starts on the next edge
        while (seen < storeCount[p] && cycle < cycleBudget[p]) begin
            @(negedge CLOCK_50);
            cycle++;
            if (storeStrobe === 1'b1) begin
                want = expectedData(storeKind[p][seen], storeLit[p][seen], x, y);
                if (seen == 0 && cycle != firstStoreCycle[p]) begin
                    $display("error at %0t: program %0d first store in cycle %0d, expected %0d",
                             $time, p, cycle, firstStoreCycle[p]);
                    bad++;
                end
                if (storeAddr !== storeAddrTab[p][seen]) begin
                    $display("error at %0t: program %0d store %0d address %h, expected %h",
                             $time, p, seen, storeAddr, storeAddrTab[p][seen]);
                    bad++;
                end
                if (storeData !== want) begin
                    $display("error at %0t: program %0d store %0d data %h, expected %h",
                             $time, p, seen, storeData, want);
                    bad++;
                end
                seen++;
            end
        end
        if (seen < storeCount[p]) begin
            $display("program %0d used its %0d-cycle budget with only %0d of %0d stores seen",
                     p, cycleBudget[p], seen, storeCount[p]);
            bad++;
        end
        finishTest(progLabel(p), bad);
    endtask

    initial begin
        CLOCK_50 = 1'b0;
        rstN = 1'b0;
        run = 1'b0;
        loadEn = 1'b0;
        loadAddr = 8'h00;
        loadData = 8'h00;
        testsRun = 0;
        testsFailed = 0;
        errorCount = 0;
        void'($urandom(45576));
        checkReset();
        for (int p = 0; p < numPrograms; p++) begin
            runProgram(p);
        end
        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (testsFailed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Twice the summed budgets leaves room for reset and image loading
    initial begin : watchdog
        int limit;
        limit = 0;
        for (int p = 0; p < numPrograms; p++) begin
            limit += cycleBudget[p];
        end
        #(2 * limit * clkPeriod);
        $display("timeout: the run did not finish within %0d clock cycles", 2 * limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
hw/cpuPkg.sv
hw/aluUnit.sv
hw/regFile.sv
hw/mainMemory.sv
hw/controlFsm.sv
hw/dataPath.sv
hw/cpuTop.sv
test/cpuTb.sv
